/* design/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    // datapath and register index widths
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // reorder buffer sizing, tag 0 is reserved for "value present"
    localparam int ROB_TAG_W = 3;
    localparam int ROB_ENTRIES = 8;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        // jumps are only recognized so they can be dropped
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_e;

    // alu operation, follows funct3 with sub and sra in the slt slots
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    // branch comparisons, straight from funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_e;

    // where a decoded instruction goes
    typedef enum logic [1:0] {
        ISSUE_NONE = 2'd0,
        ISSUE_ALU  = 2'd1,
        ISSUE_CMP  = 2'd2,
        ISSUE_LSB  = 2'd3
    } issue_class_e;

    // four-phase handshake towards the instruction queue
    typedef enum logic [1:0] {
        HS_IDLE = 2'd0,
        HS_ACK  = 2'd1
    } hs_state_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } instr_packet_t;

    typedef struct packed {
        rv32i_opcode_e          opcode;
        issue_class_e           iclass;
        alu_op_e                alu_op;
        logic [2:0]             funct3;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        imm;
        logic                   use_pc;
        logic                   use_imm;
        logic                   has_rd;
        logic                   is_store;
    } decoded_instr_t;

    // register file answer, value or tag per source
    typedef struct packed {
        logic [XLEN-1:0]      rs1_value;
        logic [ROB_TAG_W-1:0] rs1_tag;
        logic [XLEN-1:0]      rs2_value;
        logic [ROB_TAG_W-1:0] rs2_tag;
    } regfile_read_t;

    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] value;
    } rob_entry_t;

    typedef rob_entry_t [ROB_ENTRIES-1:0] rob_arr_t;

    // valid is set when tag is 0
    typedef struct packed {
        logic [XLEN-1:0]      value;
        logic [ROB_TAG_W-1:0] tag;
        logic                 valid;
    } operand_t;

    localparam operand_t OPERAND_ZERO = '{value: '0, tag: '0, valid: 1'b1};

    typedef struct packed {
        logic                 valid;
        alu_op_e              op;
        operand_t             rs1;
        operand_t             rs2;
        logic [ROB_TAG_W-1:0] rob_idx;
    } alu_rs_t;

    typedef struct packed {
        logic                 valid;
        branch_funct3_e       op;
        operand_t             rs1;
        operand_t             rs2;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      b_imm;
        logic [ROB_TAG_W-1:0] rob_idx;
    } cmp_rs_t;

    typedef struct packed {
        logic                 valid;
        logic                 is_store;
        logic [2:0]           funct3;
        operand_t             base;
        operand_t             data;
        logic [XLEN-1:0]      offset;
        logic [ROB_TAG_W-1:0] tag;
    } lsb_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        rv32i_opcode_e         opcode;
        logic [REG_ADDR_W-1:0] rd;
    } rob_alloc_t;

endpackage

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import issue_pkg::*; (
    input  instr_packet_t  instr_i,
    output decoded_instr_t dec_o
);

    logic [31:0]           instr;
    rv32i_opcode_e         opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       i_imm;
    logic [XLEN-1:0]       s_imm;
    logic [XLEN-1:0]       b_imm;
    logic [XLEN-1:0]       u_imm;
    logic                  is_slt;
    alu_op_e               alu_op;

    // raw fields
    assign instr  = instr_i.instr;
    assign opcode = rv32i_opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // sign extended immediates, no j-type needed
    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};

    // slt and sltu are not dispatched
    assign is_slt = (funct3 == 3'b010) || (funct3 == 3'b011);

    always_comb begin
        case (funct3)
            // sub only exists as a register op
            3'b000: alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
            // shift right picks arithmetic by funct7 bit 5 in both forms
            3'b101: alu_op = funct7[5] ? alu_sra : alu_srl;
            // slt slots would alias sub and sra
            3'b010, 3'b011: alu_op = alu_add;
            default: alu_op = alu_op_e'(funct3);
        endcase
        // upper immediates are plain adds
        if (opcode == op_lui || opcode == op_auipc) begin
            alu_op = alu_add;
        end
    end

    always_comb begin
        dec_o          = '0;
        dec_o.opcode   = opcode;
        dec_o.alu_op   = alu_op;
        dec_o.funct3   = funct3;
        dec_o.rs1      = rs1;
        dec_o.iclass   = ISSUE_NONE;
        case (opcode)
            op_lui, op_auipc: begin
                // rs1 bits are immediate here, do not look them up
                dec_o.rs1     = '0;
                dec_o.imm     = u_imm;
                dec_o.use_imm = 1'b1;
                dec_o.use_pc  = (opcode == op_auipc);
                dec_o.iclass  = (rd != '0) ? ISSUE_ALU : ISSUE_NONE;
            end
            op_imm: begin
                dec_o.imm     = i_imm;
                dec_o.use_imm = 1'b1;
                dec_o.iclass  = (rd != '0 && !is_slt) ? ISSUE_ALU : ISSUE_NONE;
            end
            op_reg: begin
                dec_o.rs2    = rs2;
                dec_o.iclass = (rd != '0 && !is_slt) ? ISSUE_ALU : ISSUE_NONE;
            end
            op_br: begin
                dec_o.rs2    = rs2;
                dec_o.imm    = b_imm;
                dec_o.iclass = ISSUE_CMP;
            end
            op_load: begin
                dec_o.imm    = i_imm;
                dec_o.iclass = (rd != '0) ? ISSUE_LSB : ISSUE_NONE;
            end
            op_store: begin
                dec_o.rs2      = rs2;
                dec_o.imm      = s_imm;
                dec_o.is_store = 1'b1;
                dec_o.iclass   = ISSUE_LSB;
            end
            // jal, jalr and unknown encodings are dropped
            default: begin
                dec_o.rs1 = '0;
            end
        endcase
        // only dispatched alu ops and loads rename their destination
        dec_o.has_rd = (dec_o.iclass == ISSUE_ALU) ||
                       (dec_o.iclass == ISSUE_LSB && !dec_o.is_store);
        dec_o.rd     = dec_o.has_rd ? rd : '0;
    end

endmodule

`default_nettype wire

/* design/operand_bypass.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_bypass import issue_pkg::*; (
    input  regfile_read_t regfile_i,
    input  rob_arr_t      rob_i,
    output operand_t      rs1_op_o,
    output operand_t      rs2_op_o
);

    logic rs1_hit;
    logic rs2_hit;

    // tag pending in regfile but rob already holds the result
    assign rs1_hit = (regfile_i.rs1_tag != '0) && rob_i[regfile_i.rs1_tag].ready;
    assign rs2_hit = (regfile_i.rs2_tag != '0) && rob_i[regfile_i.rs2_tag].ready;

    always_comb begin
        if (rs1_hit) begin
            rs1_op_o.value = rob_i[regfile_i.rs1_tag].value;
            rs1_op_o.tag   = '0;
        end else begin
            rs1_op_o.value = regfile_i.rs1_value;
            rs1_op_o.tag   = regfile_i.rs1_tag;
        end
        rs1_op_o.valid = (rs1_op_o.tag == '0);

        if (rs2_hit) begin
            rs2_op_o.value = rob_i[regfile_i.rs2_tag].value;
            rs2_op_o.tag   = '0;
        end else begin
            rs2_op_o.value = regfile_i.rs2_value;
            rs2_op_o.tag   = regfile_i.rs2_tag;
        end
        rs2_op_o.valid = (rs2_op_o.tag == '0);
    end

    // a tag that leaves here must still be waiting on the rob
    always_comb begin
        if (rs1_op_o.tag != '0) begin
            assert (!rob_i[rs1_op_o.tag].ready)
                else $error("rs1 forwarded tag %0d already ready", rs1_op_o.tag);
        end
        if (rs2_op_o.tag != '0) begin
            assert (!rob_i[rs2_op_o.tag].ready)
                else $error("rs2 forwarded tag %0d already ready", rs2_op_o.tag);
        end
    end

endmodule

`default_nettype wire

/* design/issue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl import issue_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_req_i,
    input  decoded_instr_t        dec_i,
    input  logic [XLEN-1:0]       pc_i,
    input  operand_t              rs1_op_i,
    input  operand_t              rs2_op_i,
    input  logic [ROB_TAG_W-1:0]  rob_free_tag_i,
    input  logic                  alu_full_i,
    input  logic                  cmp_full_i,
    input  logic                  lsb_full_i,
    output logic                  instr_ack_o,
    output alu_rs_t               alu_o,
    output cmp_rs_t               cmp_o,
    output lsb_t                  lsb_o,
    output logic                  rob_write_o,
    output rob_alloc_t            rob_alloc_o,
    output logic                  rename_en_o,
    output logic [REG_ADDR_W-1:0] rename_rd_o,
    output logic [ROB_TAG_W-1:0]  rename_tag_o
);

    hs_state_e state;
    logic      station_free;
    logic      issue_go;
    logic      dispatch;
    operand_t  src_a;
    operand_t  src_b;
    alu_rs_t   alu_entry;
    cmp_rs_t   cmp_entry;
    lsb_t      lsb_entry;

    // back-pressure from the target station only
    always_comb begin
        case (dec_i.iclass)
            ISSUE_ALU: station_free = !alu_full_i;
            ISSUE_CMP: station_free = !cmp_full_i;
            ISSUE_LSB: station_free = !lsb_full_i;
            default:   station_free = 1'b1;
        endcase
    end

    // consumed instructions still wait for a free rob tag
    assign issue_go = instr_req_i && (state == HS_IDLE) && station_free &&
                      (rob_free_tag_i != '0);
    assign dispatch = issue_go && (dec_i.iclass != ISSUE_NONE);

    // first operand: pc for auipc, zero for lui, else rs1
    always_comb begin
        if (dec_i.use_pc) begin
            src_a       = OPERAND_ZERO;
            src_a.value = pc_i;
        end else if (dec_i.opcode == op_lui) begin
            src_a = OPERAND_ZERO;
        end else begin
            src_a = rs1_op_i;
        end
        if (dec_i.use_imm) begin
            src_b       = OPERAND_ZERO;
            src_b.value = dec_i.imm;
        end else begin
            src_b = rs2_op_i;
        end
    end

    // station entries, latched only on dispatch
    always_comb begin
        alu_entry.valid   = 1'b1;
        alu_entry.op      = dec_i.alu_op;
        alu_entry.rs1     = src_a;
        alu_entry.rs2     = src_b;
        alu_entry.rob_idx = rob_free_tag_i;

        cmp_entry.valid   = 1'b1;
        cmp_entry.op      = branch_funct3_e'(dec_i.funct3);
        cmp_entry.rs1     = rs1_op_i;
        cmp_entry.rs2     = rs2_op_i;
        cmp_entry.pc      = pc_i;
        cmp_entry.b_imm   = dec_i.imm;
        cmp_entry.rob_idx = rob_free_tag_i;

        lsb_entry.valid    = 1'b1;
        lsb_entry.is_store = dec_i.is_store;
        lsb_entry.funct3   = dec_i.funct3;
        lsb_entry.base     = rs1_op_i;
        // loads carry no data
        lsb_entry.data     = dec_i.is_store ? rs2_op_i : OPERAND_ZERO;
        lsb_entry.offset   = dec_i.imm;
        lsb_entry.tag      = rob_free_tag_i;
    end

    // handshake, ack is high exactly in HS_ACK
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                HS_IDLE: if (issue_go) state <= HS_ACK;
                HS_ACK:  if (!instr_req_i) state <= HS_IDLE;
                default: state <= HS_IDLE;
            endcase
        end
    end

    assign instr_ack_o = (state == HS_ACK);

    // one-cycle pulses, payload holds until next dispatch
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_o.valid <= 1'b0;
            cmp_o.valid <= 1'b0;
            lsb_o.valid <= 1'b0;
            rob_write_o <= 1'b0;
            rename_en_o <= 1'b0;
        end else begin
            alu_o.valid <= 1'b0;
            cmp_o.valid <= 1'b0;
            lsb_o.valid <= 1'b0;
            rob_write_o <= dispatch;
            rename_en_o <= issue_go && dec_i.has_rd;
            if (dispatch && dec_i.iclass == ISSUE_ALU) alu_o <= alu_entry;
            if (dispatch && dec_i.iclass == ISSUE_CMP) cmp_o <= cmp_entry;
            if (dispatch && dec_i.iclass == ISSUE_LSB) lsb_o <= lsb_entry;
        end
    end

    // rob allocation and rename payload
    always_ff @(posedge clk) begin
        if (dispatch) begin
            rob_alloc_o.pc     <= pc_i;
            rob_alloc_o.opcode <= dec_i.opcode;
            rob_alloc_o.rd     <= dec_i.rd;
            rename_rd_o        <= dec_i.rd;
            rename_tag_o       <= rob_free_tag_i;
        end
    end

    // at most one station gets an entry per cycle
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_o.valid, cmp_o.valid, lsb_o.valid}));

    // a pulse implies its station had room at the issue edge
    assert property (@(posedge clk) disable iff (rst)
        (!alu_o.valid || !$past(alu_full_i)) &&
        (!cmp_o.valid || !$past(cmp_full_i)) &&
        (!lsb_o.valid || !$past(lsb_full_i)));

    // ack only answers a pending request
    assert property (@(posedge clk) disable iff (rst)
        $rose(instr_ack_o) |-> $past(instr_req_i));

endmodule

`default_nettype wire

/* design/issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_stage import issue_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // instruction queue, four-phase
    input  logic                  instr_req_i,
    input  instr_packet_t         instr_i,
    output logic                  instr_ack_o,
    // register file lookup
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    input  regfile_read_t         regfile_i,
    // reorder buffer state
    input  rob_arr_t              rob_i,
    input  logic [ROB_TAG_W-1:0]  rob_free_tag_i,
    // station back-pressure
    input  logic                  alu_full_i,
    input  logic                  cmp_full_i,
    input  logic                  lsb_full_i,
    // issue results
    output alu_rs_t               alu_o,
    output cmp_rs_t               cmp_o,
    output lsb_t                  lsb_o,
    output logic                  rob_write_o,
    output rob_alloc_t            rob_alloc_o,
    output logic                  rename_en_o,
    output logic [REG_ADDR_W-1:0] rename_rd_o,
    output logic [ROB_TAG_W-1:0]  rename_tag_o
);

    decoded_instr_t dec;
    operand_t       rs1_op;
    operand_t       rs2_op;

    instr_decoder decoder_i (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    // source indices go straight out to the register file
    assign rs1_o = dec.rs1;
    assign rs2_o = dec.rs2;

    operand_bypass bypass_i (
        .regfile_i (regfile_i),
        .rob_i     (rob_i),
        .rs1_op_o  (rs1_op),
        .rs2_op_o  (rs2_op)
    );

    issue_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .instr_req_i    (instr_req_i),
        .dec_i          (dec),
        .pc_i           (instr_i.pc),
        .rs1_op_i       (rs1_op),
        .rs2_op_i       (rs2_op),
        .rob_free_tag_i (rob_free_tag_i),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .lsb_full_i     (lsb_full_i),
        .instr_ack_o    (instr_ack_o),
        .alu_o          (alu_o),
        .cmp_o          (cmp_o),
        .lsb_o          (lsb_o),
        .rob_write_o    (rob_write_o),
        .rob_alloc_o    (rob_alloc_o),
        .rename_en_o    (rename_en_o),
        .rename_rd_o    (rename_rd_o),
        .rename_tag_o   (rename_tag_o)
    );

endmodule

`default_nettype wire

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* bench/tb_issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage import issue_pkg::*; ();

    localparam int N_INSTR    = 50;
    localparam int RST_CYCLES = 5;
    localparam int PERIOD_NS  = 100;
    // back-pressure kinds for one instruction
    localparam int BLOCK_NONE = 0;
    localparam int BLOCK_FULL = 1;
    localparam int BLOCK_TAG  = 2;

    logic                  clk;
    logic                  rst;
    logic                  instr_req;
    instr_packet_t         instr;
    logic                  instr_ack;
    logic [REG_ADDR_W-1:0] rs1_idx;
    logic [REG_ADDR_W-1:0] rs2_idx;
    regfile_read_t         rf_rd;
    rob_arr_t              rob;
    logic [ROB_TAG_W-1:0]  free_tag;
    logic                  alu_full;
    logic                  cmp_full;
    logic                  lsb_full;
    alu_rs_t               alu_e;
    cmp_rs_t               cmp_e;
    lsb_t                  lsb_e;
    logic                  rob_wr;
    rob_alloc_t            alloc;
    logic                  ren_en;
    logic [REG_ADDR_W-1:0] ren_rd;
    logic [ROB_TAG_W-1:0]  ren_tag;

    // register file model holds a value or pending tag per register
    logic [XLEN-1:0]      rf_val [32];
    logic [ROB_TAG_W-1:0] rf_tag [32];

    // expected results for the instruction in flight
    issue_class_e          exp_class;
    alu_rs_t               exp_alu;
    cmp_rs_t               exp_cmp;
    lsb_t                  exp_lsb;
    rob_alloc_t            exp_alloc;
    logic                  exp_has_rd;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic                  hold;

    int errors;
    int seed;
    int n_station;
    int n_rob;
    int n_ren;

    tb_clk_gen #(.PERIOD_NS(PERIOD_NS)) clk_gen_i (.clk_o(clk));

    issue_stage dut_i (
        .clk            (clk),
        .rst            (rst),
        .instr_req_i    (instr_req),
        .instr_i        (instr),
        .instr_ack_o    (instr_ack),
        .rs1_o          (rs1_idx),
        .rs2_o          (rs2_idx),
        .regfile_i      (rf_rd),
        .rob_i          (rob),
        .rob_free_tag_i (free_tag),
        .alu_full_i     (alu_full),
        .cmp_full_i     (cmp_full),
        .lsb_full_i     (lsb_full),
        .alu_o          (alu_e),
        .cmp_o          (cmp_e),
        .lsb_o          (lsb_e),
        .rob_write_o    (rob_wr),
        .rob_alloc_o    (alloc),
        .rename_en_o    (ren_en),
        .rename_rd_o    (ren_rd),
        .rename_tag_o   (ren_tag)
    );

    // register file answers the dut lookup at once
    always_comb begin
        rf_rd.rs1_value = rf_val[rs1_idx];
        rf_rd.rs1_tag   = rf_tag[rs1_idx];
        rf_rd.rs2_value = rf_val[rs2_idx];
        rf_rd.rs2_tag   = rf_tag[rs2_idx];
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic note_mismatch(input string what);
        errors = errors + 1;
        $display("mismatch at time %0t: %s", $time, what);
    endtask

    // a ready rob entry wins over a pending tag
    function automatic operand_t resolve_src(input logic [REG_ADDR_W-1:0] r);
        operand_t             op;
        logic [ROB_TAG_W-1:0] t;
        t = rf_tag[r];
        if (t != '0 && rob[t].ready) begin
            op = '{value: rob[t].value, tag: '0, valid: 1'b1};
        end else begin
            op = '{value: rf_val[r], tag: t, valid: (t == '0)};
        end
        return op;
    endfunction

    task automatic randomize_models();
        logic [31:0] r;
        for (int k = 0; k < 32; k++) begin
            rf_val[k[4:0]] = rand32();
            r = rand32();
            rf_tag[k[4:0]] = r[2:0];
        end
        // x0 never waits on anything
        rf_val[0] = '0;
        rf_tag[0] = '0;
        for (int k = 0; k < ROB_ENTRIES; k++) begin
            r = rand32();
            rob[k[2:0]].ready = r[0];
            rob[k[2:0]].value = rand32();
        end
    endtask

    // legal random rv32i word for one opcode with rd never x0
    function automatic logic [31:0] gen_instr(input logic [6:0] opc);
        logic [31:0] w;
        logic [31:0] r;
        logic [2:0]  f3;
        w  = rand32();
        r  = rand32();
        f3 = w[14:12];
        // slt kinds are covered on their own
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;
        // sb/sh/sw and lb/lh/lw widths
        if (opc == op_load || opc == op_store) f3 = {1'b0, r[1] & ~r[0], r[0]};
        if (opc == op_reg) w[31:25] = {1'b0, r[5] & (f3 == 3'b000 || f3 == 3'b101), 5'b0};
        if (opc == op_imm && f3 == 3'b001) w[31:25] = '0;
        if (opc == op_imm && f3 == 3'b101) w[31:25] = {1'b0, r[5], 5'b0};
        if (opc != op_lui && opc != op_auipc) w[14:12] = f3;
        if (w[11:7] == '0) w[11:7] = 5'd1;
        w[6:0] = opc;
        return w;
    endfunction

    // expected entries straight from the rv32i encoding
    task automatic build_expected();
        logic [31:0]           w;
        logic [6:0]            opc;
        logic [2:0]            f3;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm_i;
        logic [XLEN-1:0]       imm_s;
        logic [XLEN-1:0]       imm_b;
        logic [XLEN-1:0]       imm_u;
        operand_t              zero_op;
        operand_t              src1;
        operand_t              src2;
        alu_op_e               op;
        w       = instr.instr;
        opc     = w[6:0];
        f3      = w[14:12];
        rd      = w[11:7];
        imm_i   = {{20{w[31]}}, w[31:20]};
        imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u   = {w[31:12], 12'h000};
        zero_op = '{value: '0, tag: '0, valid: 1'b1};
        src1    = resolve_src(w[19:15]);
        src2    = resolve_src(w[24:20]);
        case (opc)
            op_lui, op_auipc: exp_class = (rd != '0) ? ISSUE_ALU : ISSUE_NONE;
            op_imm, op_reg: begin
                exp_class = (rd != '0 && f3[2:1] != 2'b01) ? ISSUE_ALU : ISSUE_NONE;
            end
            op_br:    exp_class = ISSUE_CMP;
            op_load:  exp_class = (rd != '0) ? ISSUE_LSB : ISSUE_NONE;
            op_store: exp_class = ISSUE_LSB;
            default:  exp_class = ISSUE_NONE;
        endcase
        // funct7 bit 5 is w[30]
        case (f3)
            3'b000:  op = (opc == op_reg && w[30]) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b100:  op = alu_xor;
            3'b101:  op = w[30] ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        if (opc == op_lui || opc == op_auipc) op = alu_add;

        exp_alu.valid   = 1'b1;
        exp_alu.op      = op;
        exp_alu.rs1     = src1;
        exp_alu.rs2     = src2;
        exp_alu.rob_idx = free_tag;
        if (opc == op_lui || opc == op_auipc) exp_alu.rs1 = zero_op;
        if (opc == op_auipc) exp_alu.rs1.value = instr.pc;
        // every alu form except op takes the immediate
        if (opc != op_reg) begin
            exp_alu.rs2       = zero_op;
            exp_alu.rs2.value = (opc == op_imm) ? imm_i : imm_u;
        end

        exp_cmp = '{valid: 1'b1, op: branch_funct3_e'(f3), rs1: src1, rs2: src2,
                    pc: instr.pc, b_imm: imm_b, rob_idx: free_tag};

        exp_lsb.valid    = 1'b1;
        exp_lsb.is_store = (opc == op_store);
        exp_lsb.funct3   = f3;
        exp_lsb.base     = src1;
        exp_lsb.data     = (opc == op_store) ? src2 : zero_op;
        exp_lsb.offset   = (opc == op_store) ? imm_s : imm_i;
        exp_lsb.tag      = free_tag;

        exp_has_rd = (exp_class == ISSUE_ALU) || (exp_class == ISSUE_LSB && opc != op_store);
        exp_rd     = rd;
        exp_alloc  = '{pc: instr.pc, opcode: rv32i_opcode_e'(opc),
                       rd: exp_has_rd ? rd : 5'd0};
    endtask

    // one four-phase transfer that may be held off first
    task automatic run_instr(input logic [31:0] word, input int block);
        logic [31:0]          r;
        logic [ROB_TAG_W-1:0] tag;
        int                   s0;
        int                   r0;
        int                   n0;
        int                   exp_n;
        int                   exp_r;
        @(negedge clk);
        randomize_models();
        r           = rand32();
        instr.pc    = {r[31:2], 2'b00};
        instr.instr = word;
        r           = rand32();
        tag         = (r[2:0] == '0) ? 3'd1 : r[2:0];
        free_tag    = (block == BLOCK_TAG) ? 3'd0 : tag;
        build_expected();
        // only the station this class needs is full
        alu_full = (block == BLOCK_FULL) && (exp_class == ISSUE_ALU);
        cmp_full = (block == BLOCK_FULL) && (exp_class == ISSUE_CMP);
        lsb_full = (block == BLOCK_FULL) && (exp_class == ISSUE_LSB);
        hold     = (block != BLOCK_NONE);
        s0 = n_station;
        r0 = n_rob;
        n0 = n_ren;
        instr_req = 1'b1;
        if (block != BLOCK_NONE) begin
            repeat (3) @(negedge clk);
            // new model contents at release, issue must pick up these operands
            randomize_models();
            free_tag = tag;
            alu_full = 1'b0;
            cmp_full = 1'b0;
            lsb_full = 1'b0;
            hold     = 1'b0;
            build_expected();
        end
        while (!instr_ack) @(negedge clk);
        instr_req = 1'b0;
        while (instr_ack) @(negedge clk);
        exp_n = (exp_class != ISSUE_NONE) ? 1 : 0;
        exp_r = exp_has_rd ? 1 : 0;
        assert (n_station - s0 == exp_n && n_rob - r0 == exp_n && n_ren - n0 == exp_r)
            else note_mismatch("pulse count for one instruction");
    endtask

    // pulse counters see the registered outputs of the last cycle
    always @(posedge clk) begin
        if (!rst) begin
            if (alu_e.valid) n_station = n_station + 1;
            if (cmp_e.valid) n_station = n_station + 1;
            if (lsb_e.valid) n_station = n_station + 1;
            if (rob_wr) n_rob = n_rob + 1;
            if (ren_en) n_ren = n_ren + 1;
        end
    end

    // outputs quiet during and right after reset
    assert property (@(posedge clk) $past(rst) |->
        !(instr_ack || alu_e.valid || cmp_e.valid || lsb_e.valid || rob_wr || ren_en))
        else note_mismatch("output active during reset");

    assert property (@(posedge clk) disable iff (rst)
        alu_e.valid |-> (exp_class == ISSUE_ALU && alu_e == exp_alu))
        else note_mismatch("alu station entry");

    assert property (@(posedge clk) disable iff (rst)
        cmp_e.valid |-> (exp_class == ISSUE_CMP && cmp_e == exp_cmp))
        else note_mismatch("compare station entry");

    assert property (@(posedge clk) disable iff (rst)
        lsb_e.valid |-> (exp_class == ISSUE_LSB && lsb_e == exp_lsb))
        else note_mismatch("load-store buffer entry");

    assert property (@(posedge clk) disable iff (rst)
        rob_wr |-> (exp_class != ISSUE_NONE && alloc == exp_alloc))
        else note_mismatch("rob allocation");

    assert property (@(posedge clk) disable iff (rst)
        ren_en |-> (exp_has_rd && ren_rd == exp_rd && ren_tag == free_tag))
        else note_mismatch("rename of destination");

    // nothing leaves while blocked
    assert property (@(posedge clk) disable iff (rst)
        hold |=> !(instr_ack || alu_e.valid || cmp_e.valid || lsb_e.valid || rob_wr || ren_en))
        else note_mismatch("issue while blocked");

    // ack holds as long as req does
    assert property (@(posedge clk) disable iff (rst)
        (instr_ack && instr_req) |=> instr_ack)
        else note_mismatch("ack dropped while req high");

    // ack drops one edge after req falls
    assert property (@(posedge clk) disable iff (rst)
        (instr_ack && !instr_req) |=> !instr_ack)
        else note_mismatch("ack held after req low");

    initial begin
        #((N_INSTR * 20 + RST_CYCLES) * PERIOD_NS);
        $display("timeout: instruction sequence did not complete");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [6:0]  opc;
        seed      = 32'hff8c_af79;
        errors    = 0;
        n_station = 0;
        n_rob     = 0;
        n_ren     = 0;
        rst       = 1'b1;
        instr_req = 1'b0;
        instr     = '0;
        free_tag  = 3'd1;
        alu_full  = 1'b0;
        cmp_full  = 1'b0;
        lsb_full  = 1'b0;
        hold      = 1'b0;
        rob       = '0;
        exp_class = ISSUE_NONE;
        randomize_models();
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        // 24 alu instructions
        for (int i = 0; i < 24; i++) begin
            case (i % 4)
                0:       opc = op_imm;
                1:       opc = op_reg;
                2:       opc = op_lui;
                default: opc = op_auipc;
            endcase
            run_instr(gen_instr(opc), BLOCK_NONE);
        end
        // 6 branches then 4 loads and 4 stores
        for (int i = 0; i < 6; i++) run_instr(gen_instr(op_br), BLOCK_NONE);
        for (int i = 0; i < 4; i++) run_instr(gen_instr(op_load), BLOCK_NONE);
        for (int i = 0; i < 4; i++) run_instr(gen_instr(op_store), BLOCK_NONE);

        // 8 instructions consumed without dispatch
        w = gen_instr(op_imm);
        w[11:7] = '0;
        run_instr(w, BLOCK_NONE);
        w = gen_instr(op_load);
        w[11:7] = '0;
        run_instr(w, BLOCK_NONE);
        w = gen_instr(op_lui);
        w[11:7] = '0;
        run_instr(w, BLOCK_NONE);
        // slt, sltu, slti
        w = gen_instr(op_reg);
        w[31:25] = '0;
        w[14:12] = 3'b010;
        run_instr(w, BLOCK_NONE);
        w[14:12] = 3'b011;
        run_instr(w, BLOCK_NONE);
        w = gen_instr(op_imm);
        w[14:12] = 3'b010;
        run_instr(w, BLOCK_NONE);
        w = rand32();
        w[6:0] = op_jal;
        run_instr(w, BLOCK_NONE);
        w = rand32();
        w[6:0] = op_jalr;
        run_instr(w, BLOCK_NONE);

        // 4 held off by back-pressure
        run_instr(gen_instr(op_reg), BLOCK_FULL);
        run_instr(gen_instr(op_br), BLOCK_FULL);
        run_instr(gen_instr(op_load), BLOCK_FULL);
        run_instr(gen_instr(op_store), BLOCK_TAG);

        repeat (2) @(negedge clk);
        $display("issue stage run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
design/issue_pkg.sv
design/instr_decoder.sv
design/operand_bypass.sv
design/issue_ctrl.sv
design/issue_stage.sv
bench/tb_clk_gen.sv
bench/tb_issue_stage.sv

/* Makefile */
SRCS := $(wildcard design/*.sv bench/*.sv)
SIM  := obj_dir/Vtb_issue_stage

.PHONY: all run clean

all: run

$(SIM): $(SRCS) compile.f
	verilator --binary --timing --assert --top-module tb_issue_stage -f compile.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
